//--- mcu_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus word types and the address map of the mini MCU
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mcu_pkg;

  // bus payload types
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  sel_t;

  // word index into the on-chip RAM
  typedef logic [7:0]  ram_idx_t;

  // on-chip RAM, 1 KiB at address zero
  localparam addr_t       RAM_BASE  = 32'h0000_0000;
  localparam int unsigned RAM_WORDS = 256;
  localparam addr_t       RAM_SIZE  = addr_t'(RAM_WORDS * 4);

  // peripheral block, 16 bytes
  localparam addr_t PERIPH_BASE = 32'h1000_0000;
  localparam addr_t PERIPH_SIZE = 32'h0000_0010;

  // register offsets inside the peripheral block
  localparam addr_t EXIT_OFFSET  = 32'h0000_0000;
  localparam addr_t CYCLE_OFFSET = 32'h0000_0004;

  // everything outside the two windows is unmapped

endpackage

//--- bus_arbiter.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// round-robin arbiter, core and debug Wishbone masters onto one bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module bus_arbiter
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  core_cyc_i,
  input  logic  core_stb_i,
  input  logic  core_we_i,
  input  addr_t core_adr_i,
  input  word_t core_dat_i,
  input  sel_t  core_sel_i,
  output logic  core_ack_o,
  output logic  core_err_o,
  output word_t core_dat_o,

  input  logic  debug_cyc_i,
  input  logic  debug_stb_i,
  input  logic  debug_we_i,
  input  addr_t debug_adr_i,
  input  word_t debug_dat_i,
  input  sel_t  debug_sel_i,
  output logic  debug_ack_o,
  output logic  debug_err_o,
  output word_t debug_dat_o,

  output logic  bus_cyc_o,
  output logic  bus_stb_o,
  output logic  bus_we_o,
  output addr_t bus_adr_o,
  output word_t bus_dat_o,
  output sel_t  bus_sel_o,
  input  logic  bus_ack_i,
  input  logic  bus_err_i,
  input  word_t bus_dat_i
);

  typedef enum logic [1:0] {IDLE, CORE, DEBUG} arb_state_e;

  arb_state_e state_q, state_d;
  // core held the most recent grant
  logic       last_core_q, last_core_d;

  always_comb begin
    state_d     = state_q;
    last_core_d = last_core_q;
    case (state_q)
      IDLE: begin
        // on a tie the master not served last wins
        if (core_cyc_i && (!debug_cyc_i || !last_core_q)) begin
          state_d     = CORE;
          last_core_d = 1'b1;
        end else if (debug_cyc_i) begin
          state_d     = DEBUG;
          last_core_d = 1'b0;
        end
      end
      CORE: begin
        if (!core_cyc_i) begin
          state_d = IDLE;
        end
      end
      DEBUG: begin
        if (!debug_cyc_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= IDLE;
      last_core_q <= 1'b1;
    end else begin
      state_q     <= state_d;
      last_core_q <= last_core_d;
    end
  end

  // granted master onto the bus, responses back to it only
  always_comb begin
    bus_cyc_o   = 1'b0;
    bus_stb_o   = 1'b0;
    bus_we_o    = 1'b0;
    bus_adr_o   = '0;
    bus_dat_o   = '0;
    bus_sel_o   = '0;
    core_ack_o  = 1'b0;
    core_err_o  = 1'b0;
    core_dat_o  = '0;
    debug_ack_o = 1'b0;
    debug_err_o = 1'b0;
    debug_dat_o = '0;
    case (state_q)
      CORE: begin
        bus_cyc_o  = core_cyc_i;
        bus_stb_o  = core_stb_i;
        bus_we_o   = core_we_i;
        bus_adr_o  = core_adr_i;
        bus_dat_o  = core_dat_i;
        bus_sel_o  = core_sel_i;
        core_ack_o = bus_ack_i;
        core_err_o = bus_err_i;
        core_dat_o = bus_dat_i;
      end
      DEBUG: begin
        bus_cyc_o   = debug_cyc_i;
        bus_stb_o   = debug_stb_i;
        bus_we_o    = debug_we_i;
        bus_adr_o   = debug_adr_i;
        bus_dat_o   = debug_dat_i;
        bus_sel_o   = debug_sel_i;
        debug_ack_o = bus_ack_i;
        debug_err_o = bus_err_i;
        debug_dat_o = bus_dat_i;
      end
      default: ;
    endcase
  end

endmodule

//--- system_bus.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// system bus with arbiter, address decoder, read mux and error
// responder for unmapped accesses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module system_bus
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  core_cyc_i,
  input  logic  core_stb_i,
  input  logic  core_we_i,
  input  addr_t core_adr_i,
  input  word_t core_dat_i,
  input  sel_t  core_sel_i,
  output logic  core_ack_o,
  output logic  core_err_o,
  output word_t core_dat_o,

  input  logic  debug_cyc_i,
  input  logic  debug_stb_i,
  input  logic  debug_we_i,
  input  addr_t debug_adr_i,
  input  word_t debug_dat_i,
  input  sel_t  debug_sel_i,
  output logic  debug_ack_o,
  output logic  debug_err_o,
  output word_t debug_dat_o,

  output logic  mem_cyc_o,
  output logic  mem_stb_o,
  output logic  mem_we_o,
  output addr_t mem_adr_o,
  output word_t mem_dat_o,
  output sel_t  mem_sel_o,
  input  word_t mem_dat_i,
  input  logic  mem_ack_i,

  output logic  per_cyc_o,
  output logic  per_stb_o,
  output logic  per_we_o,
  output addr_t per_adr_o,
  output word_t per_dat_o,
  output sel_t  per_sel_o,
  input  word_t per_dat_i,
  input  logic  per_ack_i
);

  // shared bus after arbitration
  logic  bus_cyc;
  logic  bus_stb;
  logic  bus_we;
  addr_t bus_adr;
  word_t bus_wdat;
  sel_t  bus_sel;
  logic  bus_ack;
  logic  bus_err;
  word_t bus_rdat;

  addr_t ram_off;
  addr_t per_off;
  logic  mem_hit;
  logic  per_hit;
  logic  err_q;

  bus_arbiter bus_arbiter_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .core_cyc_i (core_cyc_i),
    .core_stb_i (core_stb_i),
    .core_we_i  (core_we_i),
    .core_adr_i (core_adr_i),
    .core_dat_i (core_dat_i),
    .core_sel_i (core_sel_i),
    .core_ack_o (core_ack_o),
    .core_err_o (core_err_o),
    .core_dat_o (core_dat_o),
    .debug_cyc_i(debug_cyc_i),
    .debug_stb_i(debug_stb_i),
    .debug_we_i (debug_we_i),
    .debug_adr_i(debug_adr_i),
    .debug_dat_i(debug_dat_i),
    .debug_sel_i(debug_sel_i),
    .debug_ack_o(debug_ack_o),
    .debug_err_o(debug_err_o),
    .debug_dat_o(debug_dat_o),
    .bus_cyc_o  (bus_cyc),
    .bus_stb_o  (bus_stb),
    .bus_we_o   (bus_we),
    .bus_adr_o  (bus_adr),
    .bus_dat_o  (bus_wdat),
    .bus_sel_o  (bus_sel),
    .bus_ack_i  (bus_ack),
    .bus_err_i  (bus_err),
    .bus_dat_i  (bus_rdat)
  );

  // window decode, the low address bits never matter as both windows are word aligned
  assign ram_off = bus_adr - RAM_BASE;
  assign per_off = bus_adr - PERIPH_BASE;
  assign mem_hit = ram_off < RAM_SIZE;
  assign per_hit = per_off < PERIPH_SIZE;

  assign mem_cyc_o = bus_cyc & mem_hit;
  assign mem_stb_o = bus_stb & mem_hit;
  assign mem_we_o  = bus_we;
  assign mem_adr_o = bus_adr;
  assign mem_dat_o = bus_wdat;
  assign mem_sel_o = bus_sel;

  assign per_cyc_o = bus_cyc & per_hit;
  assign per_stb_o = bus_stb & per_hit;
  assign per_we_o  = bus_we;
  assign per_adr_o = bus_adr;
  assign per_dat_o = bus_wdat;
  assign per_sel_o = bus_sel;

  // unmapped access, one-cycle err like a slave ack
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= bus_cyc & bus_stb & ~mem_hit & ~per_hit & ~err_q;
    end
  end

  assign bus_err  = err_q;
  assign bus_ack  = mem_ack_i | per_ack_i;
  assign bus_rdat = mem_hit ? mem_dat_i : (per_hit ? per_dat_i : '0);

endmodule

//--- memory_subsystem.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// on-chip word RAM with byte selects behind a Wishbone slave port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module memory_subsystem
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  word_t dat_i,
  input  sel_t  sel_i,
  output word_t dat_o,
  output logic  ack_o
);

  word_t    mem_q [RAM_WORDS];
  addr_t    off;
  ram_idx_t idx;
  logic     req;

  assign off = adr_i - RAM_BASE;
  assign idx = ram_idx_t'(off >> 2);

  // new request only, the ack cycle must not start a second one
  assign req = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      if (we_i) begin
        for (int b = 0; b < $bits(sel_t); b++) begin
          if (sel_i[b]) begin
            mem_q[idx][8*b +: 8] <= dat_i[8*b +: 8];
          end
        end
      end
      // a write returns the old word
      dat_o <= mem_q[idx];
    end
  end

endmodule

//--- peripheral_subsystem.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// peripheral block with exit register and free-running cycle counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module peripheral_subsystem
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  cyc_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  addr_t adr_i,
  input  word_t dat_i,
  output word_t dat_o,
  output logic  ack_o,
  output word_t exit_value_o,
  output logic  exit_valid_o
);

  addr_t off;
  logic  req;
  word_t exit_value_q;
  logic  exit_valid_q;
  word_t cycle_q;

  // word offset inside the block
  assign off = {adr_i[31:2], 2'b00} - PERIPH_BASE;
  assign req = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= req;
    end
  end

  // counts every cycle since reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // exit register, valid stays set until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
    end else if (req && we_i && off == EXIT_OFFSET) begin
      exit_value_q <= dat_i;
      exit_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      case (off)
        EXIT_OFFSET:  dat_o <= exit_value_q;
        CYCLE_OFFSET: dat_o <= cycle_q;
        default:      dat_o <= '0;
      endcase
    end
  end

  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;

endmodule

//--- mini_mcu.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mini MCU top, system bus with RAM and peripheral slaves
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mini_mcu
  import mcu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,

  input  logic  core_cyc_i,
  input  logic  core_stb_i,
  input  logic  core_we_i,
  input  addr_t core_adr_i,
  input  word_t core_dat_i,
  input  sel_t  core_sel_i,
  output logic  core_ack_o,
  output logic  core_err_o,
  output word_t core_dat_o,

  input  logic  debug_cyc_i,
  input  logic  debug_stb_i,
  input  logic  debug_we_i,
  input  addr_t debug_adr_i,
  input  word_t debug_dat_i,
  input  sel_t  debug_sel_i,
  output logic  debug_ack_o,
  output logic  debug_err_o,
  output word_t debug_dat_o,

  output word_t exit_value_o,
  output logic  exit_valid_o
);

  // RAM slave port
  logic  mem_cyc;
  logic  mem_stb;
  logic  mem_we;
  addr_t mem_adr;
  word_t mem_wdat;
  sel_t  mem_sel;
  word_t mem_rdat;
  logic  mem_ack;

  // peripheral slave port
  logic  per_cyc;
  logic  per_stb;
  logic  per_we;
  addr_t per_adr;
  word_t per_wdat;
  word_t per_rdat;
  logic  per_ack;

  system_bus system_bus_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .core_cyc_i (core_cyc_i),
    .core_stb_i (core_stb_i),
    .core_we_i  (core_we_i),
    .core_adr_i (core_adr_i),
    .core_dat_i (core_dat_i),
    .core_sel_i (core_sel_i),
    .core_ack_o (core_ack_o),
    .core_err_o (core_err_o),
    .core_dat_o (core_dat_o),
    .debug_cyc_i(debug_cyc_i),
    .debug_stb_i(debug_stb_i),
    .debug_we_i (debug_we_i),
    .debug_adr_i(debug_adr_i),
    .debug_dat_i(debug_dat_i),
    .debug_sel_i(debug_sel_i),
    .debug_ack_o(debug_ack_o),
    .debug_err_o(debug_err_o),
    .debug_dat_o(debug_dat_o),
    .mem_cyc_o  (mem_cyc),
    .mem_stb_o  (mem_stb),
    .mem_we_o   (mem_we),
    .mem_adr_o  (mem_adr),
    .mem_dat_o  (mem_wdat),
    .mem_sel_o  (mem_sel),
    .mem_dat_i  (mem_rdat),
    .mem_ack_i  (mem_ack),
    .per_cyc_o  (per_cyc),
    .per_stb_o  (per_stb),
    .per_we_o   (per_we),
    .per_adr_o  (per_adr),
    .per_dat_o  (per_wdat),
    // peripheral registers are written as whole words
    .per_sel_o  (),
    .per_dat_i  (per_rdat),
    .per_ack_i  (per_ack)
  );

  memory_subsystem memory_subsystem_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .cyc_i  (mem_cyc),
    .stb_i  (mem_stb),
    .we_i   (mem_we),
    .adr_i  (mem_adr),
    .dat_i  (mem_wdat),
    .sel_i  (mem_sel),
    .dat_o  (mem_rdat),
    .ack_o  (mem_ack)
  );

  peripheral_subsystem peripheral_subsystem_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cyc_i       (per_cyc),
    .stb_i       (per_stb),
    .we_i        (per_we),
    .adr_i       (per_adr),
    .dat_i       (per_wdat),
    .dat_o       (per_rdat),
    .ack_o       (per_ack),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

//--- mini_mcu_properties.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone handshake, reset and round-robin fairness assertions for mini_mcu
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module mini_mcu_properties (
  input logic clk_i,
  input logic rst_n_i,
  input logic core_cyc_i,
  input logic core_stb_i,
  input logic core_ack_i,
  input logic core_err_i,
  input logic debug_cyc_i,
  input logic debug_stb_i,
  input logic debug_ack_i,
  input logic debug_err_i,
  input logic exit_valid_i
);

  logic core_done;
  logic debug_done;
  // one master finished while the other kept waiting
  logic core_streak_q;
  logic debug_streak_q;

  assign core_done  = core_ack_i | core_err_i;
  assign debug_done = debug_ack_i | debug_err_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_streak_q  <= 1'b0;
      debug_streak_q <= 1'b0;
    end else begin
      if (debug_done || !debug_cyc_i) begin
        core_streak_q <= 1'b0;
      end else if (core_done) begin
        core_streak_q <= 1'b1;
      end
      if (core_done || !core_cyc_i) begin
        debug_streak_q <= 1'b0;
      end else if (debug_done) begin
        debug_streak_q <= 1'b1;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(core_ack_i && core_err_i) && !(debug_ack_i && debug_err_i))
    else $error("ack and err high together");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_done |-> core_cyc_i && core_stb_i)
    else $error("core response without cyc and stb");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_done |-> debug_cyc_i && debug_stb_i)
    else $error("debug response without cyc and stb");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_done |=> !core_done)
    else $error("core response in two consecutive cycles");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    debug_done |=> !debug_done)
    else $error("debug response in two consecutive cycles");

  // the waiting master must be served before a second grant
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(core_done && core_streak_q) && !(debug_done && debug_streak_q))
    else $error("one master granted twice while the other waited");

  assert property (@(posedge clk_i)
    !rst_n_i |-> !core_done && !debug_done && !exit_valid_i)
    else $error("response or exit_valid high during reset");

endmodule

//--- tb_mini_mcu.sv
`timescale 1ns/1ps
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for mini_mcu with core and debug master tasks and a RAM model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_mini_mcu
  import mcu_pkg::*;
();

  logic  clk;
  logic  rst_n;
  logic  core_cyc;
  logic  core_stb;
  logic  core_we;
  addr_t core_adr;
  word_t core_dat;
  sel_t  core_sel;
  logic  core_ack;
  logic  core_err;
  word_t core_rdat;
  logic  debug_cyc;
  logic  debug_stb;
  logic  debug_we;
  addr_t debug_adr;
  word_t debug_dat;
  sel_t  debug_sel;
  logic  debug_ack;
  logic  debug_err;
  word_t debug_rdat;
  word_t exit_value;
  logic  exit_valid;

  // expected RAM contents
  word_t ref_mem [RAM_WORDS];

  mini_mcu mini_mcu_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .core_cyc_i  (core_cyc),
    .core_stb_i  (core_stb),
    .core_we_i   (core_we),
    .core_adr_i  (core_adr),
    .core_dat_i  (core_dat),
    .core_sel_i  (core_sel),
    .core_ack_o  (core_ack),
    .core_err_o  (core_err),
    .core_dat_o  (core_rdat),
    .debug_cyc_i (debug_cyc),
    .debug_stb_i (debug_stb),
    .debug_we_i  (debug_we),
    .debug_adr_i (debug_adr),
    .debug_dat_i (debug_dat),
    .debug_sel_i (debug_sel),
    .debug_ack_o (debug_ack),
    .debug_err_o (debug_err),
    .debug_dat_o (debug_rdat),
    .exit_value_o(exit_value),
    .exit_valid_o(exit_valid)
  );

  bind mini_mcu mini_mcu_properties mini_mcu_properties_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .core_cyc_i  (core_cyc_i),
    .core_stb_i  (core_stb_i),
    .core_ack_i  (core_ack_o),
    .core_err_i  (core_err_o),
    .debug_cyc_i (debug_cyc_i),
    .debug_stb_i (debug_stb_i),
    .debug_ack_i (debug_ack_o),
    .debug_err_i (debug_err_o),
    .exit_valid_i(exit_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s returned %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic expect_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("ERROR at %0t: %s does not hold", $time, what);
      stop_run();
    end
  endtask

  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input sel_t sel);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic addr_t ram_addr(input ram_idx_t idx);
    return RAM_BASE + {22'd0, idx, 2'b00};
  endfunction

  task automatic core_xfer(input logic we, input addr_t adr, input word_t wdat,
                           input sel_t sel, output word_t rdat, output logic err);
    int cycles;
    cycles = 0;
    @(posedge clk);
    core_cyc <= 1'b1;
    core_stb <= 1'b1;
    core_we  <= we;
    core_adr <= adr;
    core_dat <= wdat;
    core_sel <= sel;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) begin
        $display("core port got neither ack nor err within 50 cycles at %0t", $time);
        stop_run();
      end
    end while (!core_ack && !core_err);
    rdat = core_rdat;
    err  = core_err;
    @(posedge clk);
    core_cyc <= 1'b0;
    core_stb <= 1'b0;
    core_we  <= 1'b0;
  endtask

  task automatic debug_xfer(input logic we, input addr_t adr, input word_t wdat,
                            input sel_t sel, output word_t rdat, output logic err);
    int cycles;
    cycles = 0;
    @(posedge clk);
    debug_cyc <= 1'b1;
    debug_stb <= 1'b1;
    debug_we  <= we;
    debug_adr <= adr;
    debug_dat <= wdat;
    debug_sel <= sel;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) begin
        $display("debug port got neither ack nor err within 50 cycles at %0t", $time);
        stop_run();
      end
    end while (!debug_ack && !debug_err);
    rdat = debug_rdat;
    err  = debug_err;
    @(posedge clk);
    debug_cyc <= 1'b0;
    debug_stb <= 1'b0;
    debug_we  <= 1'b0;
  endtask

  initial begin
    word_t    rdat;
    logic     err;
    word_t    wdat;
    sel_t     sel;
    ram_idx_t idx;
    ram_idx_t idx_list[$];
    word_t    core_rd;
    word_t    debug_rd;
    logic     core_er;
    logic     debug_er;
    word_t    core_wd;
    word_t    debug_wd;
    word_t    cyc_a;
    word_t    cyc_b;
    int       wait_cycles;

    void'($urandom(38));
    rst_n     = 1'b0;
    core_cyc  = 1'b0;
    core_stb  = 1'b0;
    core_we   = 1'b0;
    core_adr  = '0;
    core_dat  = '0;
    core_sel  = '0;
    debug_cyc = 1'b0;
    debug_stb = 1'b0;
    debug_we  = 1'b0;
    debug_adr = '0;
    debug_dat = '0;
    debug_sel = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // RAM through both ports with word 0 kept for the unmapped check
    for (int i = 0; i < 8; i++) begin
      idx = (i == 0) ? 8'd0 : ram_idx_t'($urandom_range(1, 199));
      idx_list.push_back(idx);
      wdat = $urandom;
      core_xfer(1'b1, ram_addr(idx), wdat, 4'hF, rdat, err);
      expect_true("core full word write without err", !err);
      ref_mem[idx] = wdat;
      wdat = $urandom;
      sel  = sel_t'($urandom);
      debug_xfer(1'b1, ram_addr(idx), wdat, sel, rdat, err);
      expect_true("debug byte select write without err", !err);
      ref_mem[idx] = merge_bytes(ref_mem[idx], wdat, sel);
      core_xfer(1'b0, ram_addr(idx), '0, 4'hF, rdat, err);
      check_word("core RAM read", rdat, ref_mem[idx]);
      debug_xfer(1'b0, ram_addr(idx), '0, 4'hF, rdat, err);
      check_word("debug RAM read", rdat, ref_mem[idx]);
    end

    // both masters start in the same cycle
    core_wd  = $urandom;
    debug_wd = $urandom;
    fork
      begin
        core_xfer(1'b1, ram_addr(8'd200), core_wd, 4'hF, core_rd, core_er);
        core_xfer(1'b0, ram_addr(8'd200), '0, 4'hF, core_rd, core_er);
      end
      begin
        debug_xfer(1'b1, ram_addr(8'd201), debug_wd, 4'hF, debug_rd, debug_er);
        debug_xfer(1'b0, ram_addr(8'd201), '0, 4'hF, debug_rd, debug_er);
      end
    join
    ref_mem[200] = core_wd;
    ref_mem[201] = debug_wd;
    expect_true("core read under contention without err", !core_er);
    expect_true("debug read under contention without err", !debug_er);
    check_word("core read under contention", core_rd, ref_mem[200]);
    check_word("debug read under contention", debug_rd, ref_mem[201]);

    // unmapped accesses end in err and leave the RAM alone
    core_xfer(1'b1, 32'h2000_0000, 32'hDEAD_BEEF, 4'hF, rdat, err);
    expect_true("unmapped core write ends in err", err);
    debug_xfer(1'b0, 32'h1000_0010, '0, 4'hF, rdat, err);
    expect_true("unmapped debug read ends in err", err);
    foreach (idx_list[i]) begin
      core_xfer(1'b0, ram_addr(idx_list[i]), '0, 4'hF, rdat, err);
      check_word("RAM read after unmapped write", rdat, ref_mem[idx_list[i]]);
    end

    // exit register
    expect_true("exit_valid_o low before the exit write", !exit_valid);
    wdat = $urandom;
    debug_xfer(1'b1, PERIPH_BASE + EXIT_OFFSET, wdat, 4'hF, rdat, err);
    wait_cycles = 0;
    while (!exit_valid) begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > 2) begin
        $display("exit_valid_o did not rise within 2 cycles of the exit write ack");
        stop_run();
      end
    end
    check_word("exit_value_o", exit_value, wdat);
    core_xfer(1'b0, ram_addr(8'd0), '0, 4'hF, rdat, err);
    debug_xfer(1'b1, ram_addr(8'd0), ref_mem[0], 4'hF, rdat, err);
    expect_true("exit_valid_o stays set", exit_valid);
    core_xfer(1'b0, PERIPH_BASE + EXIT_OFFSET, '0, 4'hF, rdat, err);
    check_word("exit register read", rdat, wdat);

    // cycle counter
    core_xfer(1'b0, PERIPH_BASE + CYCLE_OFFSET, '0, 4'hF, cyc_a, err);
    debug_xfer(1'b0, PERIPH_BASE + CYCLE_OFFSET, '0, 4'hF, cyc_b, err);
    expect_true("first cycle count is nonzero", cyc_a != 0);
    expect_true("cycle count increases", cyc_b > cyc_a);

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- verilog.f
mcu_pkg.sv
bus_arbiter.sv
system_bus.sv
memory_subsystem.sv
peripheral_subsystem.sv
mini_mcu.sv
mini_mcu_properties.sv
tb_mini_mcu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mini_mcu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mini_mcu -f verilog.f -o sim_mini_mcu
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_mini_mcu
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation ended with status $status"
  exit "$status"
fi

exit 0
